/* flist.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/line_assembler.sv
hdl/inst_queue.sv
hdl/fetch_top.sv
bench/clk_gen.sv
bench/bmem_model.sv
bench/fetch_tb.sv

/* bench/fetch_tb.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_tb;

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        DQ_ALWAYS,
        DQ_RANDOM,
        DQ_STALL
    } deq_mode_t;

    typedef struct packed {
        logic           redirect;
        logic   [31:0]  target;
        logic   [15:0]  n_deq;
        deq_mode_t      mode;
        logic   [7:0]   stall;          // Idle cycles before dequeue in DQ_STALL
    } test_row_t;

    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 400;     // Cycles without a pop

    logic           clk;
    logic           rst;
    logic           redirect;
    logic   [31:0]  redirect_pc;
    logic           deq;
    iq_entry_t      entry;
    logic           valid;
    logic   [31:0]  bmem_addr;
    logic           bmem_read;
    logic           bmem_ready;
    logic   [31:0]  bmem_raddr;
    logic   [63:0]  bmem_rdata;
    logic           bmem_rvalid;

    test_row_t      tests [NUM_TESTS];
    logic   [31:0]  exp_pc;
    integer         seed;
    int             errors;
    int             bus_errors;
    int             failed_tests;
    int             reset_wait;

    clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

    bmem_model bmem_model_i (
        .clk(clk),
        .rst(rst),
        .addr_i(bmem_addr),
        .read_i(bmem_read),
        .ready_o(bmem_ready),
        .raddr_o(bmem_raddr),
        .rdata_o(bmem_rdata),
        .rvalid_o(bmem_rvalid)
    );

    fetch_top fetch_top_i (
        .clk(clk),
        .rst(rst),
        .redirect_i(redirect),
        .redirect_pc_i(redirect_pc),
        .deq_i(deq),
        .entry_o(entry),
        .valid_o(valid),
        .bmem_addr_o(bmem_addr),
        .bmem_read_o(bmem_read),
        .bmem_ready_i(bmem_ready),
        .bmem_raddr_i(bmem_raddr),
        .bmem_rdata_i(bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid)
    );

    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        return {~pc[31:16], pc[15:0]};
    endfunction

    // Line reads go out line aligned and only while the bus is ready
    always @(posedge clk) begin
        if ((rst === 1'b0) && (bmem_read === 1'b1)) begin
            if (bmem_ready !== 1'b1) begin
                $display("MISMATCH at %0t: bmem_read issued while bmem_ready low", $time);
                bus_errors++;
            end
            if (bmem_addr[4:0] !== 5'd0) begin
                $display("MISMATCH at %0t: bmem_addr %h not line aligned",
                         $time, bmem_addr);
                bus_errors++;
            end
        end
    end

    task automatic run_test(input test_row_t row, input int idx);
        int got;
        int cycles;
        int timer;
        int errs;
        got    = 0;
        cycles = 0;
        timer  = 0;
        errs   = 0;
        if (row.redirect) begin
            redirect    = 1'b1;
            redirect_pc = row.target;
            deq         = 1'b0;
            exp_pc      = row.target;
            @(posedge clk);
            #5 redirect = 1'b0;
        end
        while ((got < row.n_deq) && (timer < TIMEOUT)) begin
            case (row.mode)
                DQ_ALWAYS: deq = 1'b1;
                DQ_RANDOM: deq = (({$random(seed)} % 2) != 0);
                default:   deq = (cycles >= row.stall);
            endcase
            @(posedge clk);
            if (deq && valid) begin     // Head entry leaves at this edge
                if (entry.pc !== exp_pc) begin
                    $display("MISMATCH at %0t: test %0d pc expected %h got %h",
                             $time, idx, exp_pc, entry.pc);
                    errs++;
                end
                if (entry.inst !== expected_inst(exp_pc)) begin
                    $display("MISMATCH at %0t: test %0d inst at %h expected %h got %h",
                             $time, idx, exp_pc, expected_inst(exp_pc), entry.inst);
                    errs++;
                end
                exp_pc = exp_pc + 32'd4;
                got++;
                timer = 0;
            end else begin
                timer++;
            end
            cycles++;
            #5;
        end
        deq = 1'b0;
        if (got < row.n_deq) begin
            $display("Test %0d timed out after %0d of %0d entries", idx, got, row.n_deq);
            errs++;
        end
        errors += errs;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %0d entries, %0d errors", idx,
                 (errs == 0) ? "ok" : "failed", got, errs);
    endtask

    initial begin
        redirect     = 1'b0;
        redirect_pc  = '0;
        deq          = 1'b0;
        seed         = 32'h1e01_dfb1;
        errors       = 0;
        bus_errors   = 0;
        failed_tests = 0;
        exp_pc       = `FETCH_RESET_VEC;

        tests[0] = '{1'b0, 32'h0000_0000, 16'd20, DQ_ALWAYS, 8'd0};  // From reset vector
        tests[1] = '{1'b0, 32'h0000_0000, 16'd24, DQ_ALWAYS, 8'd0};  // More lines
        tests[2] = '{1'b1, 32'h0040_1234, 16'd12, DQ_ALWAYS, 8'd0};  // Redirect mid fetch
        tests[3] = '{1'b1, 32'h1ece_b010, 16'd10, DQ_ALWAYS, 8'd0};  // Back to cached line
        tests[4] = '{1'b0, 32'h0000_0000, 16'd40, DQ_STALL,  8'd60}; // Back-pressure
        tests[5] = '{1'b1, 32'h2000_0f04, 16'd100, DQ_RANDOM, 8'd0};

        reset_wait = 0;
        while ((rst !== 1'b0) && (reset_wait < 50)) begin
            @(posedge clk);
            reset_wait++;
        end
        if (rst !== 1'b0) begin
            $display("Reset never released");
            errors++;
        end
        if (valid !== 1'b0) begin
            $display("MISMATCH at %0t: valid_o expected 0 after reset got %b", $time, valid);
            errors++;
        end
        #5;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(tests[i], i);
        end

        errors += bus_errors;
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : fetch_tb

/* bench/bmem_model.sv */
`timescale 1ns/100ps

module bmem_model (
    input   logic           clk,
    input   logic           rst,

    input   logic   [31:0]  addr_i,
    input   logic           read_i,
    output  logic           ready_o,

    output  logic   [31:0]  raddr_o,
    output  logic   [63:0]  rdata_o,
    output  logic           rvalid_o
);

    logic   [31:0]  pending [$];        // Line reads not yet served
    logic   [31:0]  cur_addr;
    integer         seed;
    int             wait_cnt;
    int             beat;
    logic           busy;
    logic           in_reset;           // Reset as seen at the edge

    // Each word holds its own address, upper half inverted
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    initial begin
        seed     = 32'h1e01_dfb1;
        ready_o  = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
        rvalid_o = 1'b0;
        cur_addr = '0;
        wait_cnt = 0;
        beat     = 0;
        busy     = 1'b0;
        in_reset = 1'b1;
    end

    always @(posedge clk) begin
        in_reset = rst;
        if (read_i && !in_reset) begin
            pending.push_back(addr_i);
        end
        #5;
        rvalid_o = 1'b0;
        if (in_reset) begin
            pending.delete();
            busy    = 1'b0;
            ready_o = 1'b0;
        end else begin
            ready_o = (($random(seed) & 7) != 0);   // Drops about one cycle in eight
            if (!busy && (pending.size() != 0)) begin
                cur_addr = pending.pop_front();
                wait_cnt = 2 + ({$random(seed)} % 8);
                beat     = 0;
                busy     = 1'b1;
            end
            if (busy) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else if (($random(seed) & 3) != 0) begin   // Random gaps between beats
                    rvalid_o = 1'b1;
                    raddr_o  = cur_addr;
                    rdata_o  = {mem_word(cur_addr + 32'(8*beat + 4)),
                                mem_word(cur_addr + 32'(8*beat))};
                    beat++;
                    if (beat == 4) begin
                        busy = 1'b0;
                    end
                end
            end
        end
    end

endmodule : bmem_model

/* bench/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output  logic   clk_o,
    output  logic   rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;     // 40 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #5 rst_o = 1'b0;
    end

endmodule : clk_gen

/* hdl/fetch_top.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_top (
    input   logic                       clk,
    input   logic                       rst,

    input   logic                       redirect_i,
    input   logic   [31:0]              redirect_pc_i,

    input   logic                       deq_i,
    output  fetch_pkg::iq_entry_t       entry_o,
    output  logic                       valid_o,

    output  logic   [31:0]              bmem_addr_o,
    output  logic                       bmem_read_o,
    input   logic                       bmem_ready_i,

    input   logic   [31:0]              bmem_raddr_i,
    input   logic   [`BEAT_BITS-1:0]    bmem_rdata_i,
    input   logic                       bmem_rvalid_i
);

    import fetch_pkg::*;

    ic_req_t                    ic_req;
    ic_resp_t                   ic_resp;
    logic                       iq_space;
    logic [`IC_LINE_BITS-1:0]   line;
    logic                       line_valid;

    fetch_unit fetch_unit_i (
        .clk(clk),
        .rst(rst),
        .redirect_i(redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .space_i(iq_space),
        .bmem_ready_i(bmem_ready_i),
        .resp_i(ic_resp),
        .req_o(ic_req)
    );

    icache icache_i (
        .clk(clk),
        .rst(rst),
        .req_i(ic_req),
        .flush_i(redirect_i),
        .line_valid_i(line_valid),
        .line_i(line),
        .resp_o(ic_resp),
        .bmem_addr_o(bmem_addr_o),
        .bmem_read_o(bmem_read_o)
    );

    line_assembler line_assembler_i (
        .clk(clk),
        .rst(rst),
        .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .bmem_raddr_i(bmem_raddr_i),
        .line_o(line),
        .line_valid_o(line_valid)
    );

    inst_queue inst_queue_i (
        .clk(clk),
        .rst(rst),
        .flush_i(redirect_i),
        .enq_i(ic_resp.valid),          // Same pulse as the response
        .entry_i(iq_entry_t'{pc: ic_resp.pc, inst: ic_resp.inst}),
        .deq_i(deq_i),
        .entry_o(entry_o),
        .valid_o(valid_o),
        .space_o(iq_space)
    );

endmodule : fetch_top

/* hdl/inst_queue.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module inst_queue (
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   flush_i,

    input   logic                   enq_i,
    input   fetch_pkg::iq_entry_t   entry_i,

    input   logic                   deq_i,
    output  fetch_pkg::iq_entry_t   entry_o,
    output  logic                   valid_o,

    output  logic                   space_o
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam logic [PTR_W:0] FULL      = `IQ_DEPTH;
    localparam logic [PTR_W:0] SPACE_MAX = `IQ_DEPTH - 2;

    iq_entry_t              mem     [`IQ_DEPTH];
    logic   [PTR_W-1:0]     rd_ptr;
    logic   [PTR_W-1:0]     wr_ptr;
    logic   [PTR_W:0]       count;
    logic                   pop;

    assign pop     = deq_i && valid_o;
    assign valid_o = (count != '0);
    assign space_o = (count <= SPACE_MAX);     // Room for the request in flight
    assign entry_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, enq_i} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (enq_i && !flush_i) |-> (count < FULL)
    ) else $error("inst_queue: enqueue while full");

endmodule : inst_queue

/* hdl/line_assembler.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module line_assembler (
    input   logic                       clk,
    input   logic                       rst,

    input   logic   [`BEAT_BITS-1:0]    bmem_rdata_i,
    input   logic                       bmem_rvalid_i,
    input   logic   [31:0]              bmem_raddr_i,

    output  logic [`IC_LINE_BITS-1:0]   line_o,
    output  logic                       line_valid_o
);

    localparam int BEAT_W = $clog2(`BEATS_PER_LINE);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`BEATS_PER_LINE - 1);

    logic   [BEAT_W-1:0]    beat_q;         // Slot for the next beat
    logic   [31:0]          burst_addr_q;   // Line address of the current burst

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q       <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= bmem_rvalid_i && (beat_q == LAST_BEAT);
            if (bmem_rvalid_i) begin
                beat_q <= beat_q + 1'b1;    // Wraps after the last beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_o[beat_q*`BEAT_BITS +: `BEAT_BITS] <= bmem_rdata_i;    // Lowest beat first
            if (beat_q == '0) begin
                burst_addr_q <= bmem_raddr_i;
            end
        end
    end

    same_burst_addr: assert property (
        @(posedge clk) disable iff (rst)
        (bmem_rvalid_i && (beat_q != '0)) |-> (bmem_raddr_i == burst_addr_q)
    ) else $error("line_assembler: bmem_raddr changed inside a burst");

endmodule : line_assembler

/* hdl/icache.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module icache (
    input   logic                       clk,
    input   logic                       rst,

    input   fetch_pkg::ic_req_t         req_i,
    input   logic                       flush_i,

    input   logic                       line_valid_i,
    input   logic [`IC_LINE_BITS-1:0]   line_i,

    output  fetch_pkg::ic_resp_t        resp_o,

    output  logic   [31:0]              bmem_addr_o,
    output  logic                       bmem_read_o
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LINE,
        RESPOND
    } state_t;

    localparam int LINE_OFS = `IC_WORD_BITS + `IC_BYTE_BITS;

    logic   [`IC_TAG_BITS-1:0]      tag_arr     [`IC_SETS];
    logic   [`IC_LINE_BITS-1:0]     data_arr    [`IC_SETS];
    logic   [`IC_SETS-1:0]          valid_arr;

    state_t         state;
    fetch_addr_t    miss_q;             // Address of the newest line read
    logic   [2:0]   lines_out_q;        // Line reads still to come back

    logic           hit;
    logic           miss_start;
    logic           fill;
    logic   [31:0]  hit_word;
    logic   [31:0]  fill_word;

    logic           resp_valid_q;
    logic   [31:0]  resp_inst_q;
    logic   [31:0]  resp_pc_q;

    assign hit = valid_arr[req_i.addr.f.idx]
              && (tag_arr[req_i.addr.f.idx] == req_i.addr.f.tag);

    assign miss_start = (state == IDLE) && req_i.valid && !hit;

    // Older lines of a flushed miss are dropped, the newest one fills
    assign fill = line_valid_i && (lines_out_q == 3'd1);

    assign hit_word  = data_arr[req_i.addr.f.idx][req_i.addr.f.word*32 +: 32];
    assign fill_word = line_i[miss_q.f.word*32 +: 32];

    assign bmem_read_o = miss_start;
    assign bmem_addr_o = {req_i.addr.raw[31:LINE_OFS], {LINE_OFS{1'b0}}};

    always_comb begin
        resp_o.valid = resp_valid_q;
        resp_o.inst  = resp_inst_q;
        resp_o.pc    = resp_pc_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            valid_arr    <= '0;
            lines_out_q  <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            lines_out_q  <= lines_out_q + {2'b00, miss_start} - {2'b00, line_valid_i};
            if (fill) begin
                valid_arr[miss_q.f.idx] <= 1'b1;
            end
            unique case (state)
                IDLE: begin
                    if (req_i.valid && hit) begin
                        resp_valid_q <= 1'b1;
                    end else if (miss_start) begin
                        state <= WAIT_LINE;
                    end
                end
                WAIT_LINE: begin
                    if (flush_i) begin
                        state <= IDLE;          // Fill goes on silently
                    end else if (fill) begin
                        state        <= RESPOND;
                        resp_valid_q <= 1'b1;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[miss_q.f.idx]  <= miss_q.f.tag;
            data_arr[miss_q.f.idx] <= line_i;
        end
        if (miss_start) begin
            miss_q <= req_i.addr;
        end
        if (req_i.valid) begin
            resp_inst_q <= hit_word;
            resp_pc_q   <= req_i.addr.raw;
        end else if (fill) begin
            resp_inst_q <= fill_word;
            resp_pc_q   <= miss_q.raw;
        end
    end

    // Every returning line answers a read sent earlier
    line_expected: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_i |-> (lines_out_q != '0)
    ) else $error("icache: line returned with no read outstanding");

endmodule : icache

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_unit (
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   redirect_i,
    input   logic   [31:0]          redirect_pc_i,

    input   logic                   space_i,
    input   logic                   bmem_ready_i,

    input   fetch_pkg::ic_resp_t    resp_i,
    output  fetch_pkg::ic_req_t     req_o
);

    import fetch_pkg::*;

    fetch_addr_t    pc;
    logic           outstanding;        // Request sent, response not yet back
    logic           issue;

    // One request in flight at a time, never in a redirect cycle
    assign issue = !outstanding && space_i && bmem_ready_i && !redirect_i;

    always_comb begin
        req_o.valid = issue;
        req_o.addr  = pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc.raw      <= `FETCH_RESET_VEC;
            outstanding <= 1'b0;
        end else if (redirect_i) begin
            pc.raw      <= redirect_pc_i;
            outstanding <= 1'b0;        // Cache drops the old response
        end else if (issue) begin
            outstanding <= 1'b1;
        end else if (resp_i.valid) begin
            outstanding <= 1'b0;
            pc.raw      <= pc.raw + 32'd4;
        end
    end

    // A response only answers the request still in flight
    resp_in_flight: assert property (
        @(posedge clk) disable iff (rst)
        resp_i.valid |-> outstanding
    ) else $error("fetch_unit: response without an outstanding request");

endmodule : fetch_unit

/* hdl/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    // Address split as the cache sees it
    typedef struct packed {
        logic   [`IC_TAG_BITS-1:0]      tag;
        logic   [`IC_SET_BITS-1:0]      idx;
        logic   [`IC_WORD_BITS-1:0]     word;
        logic   [`IC_BYTE_BITS-1:0]     ofs;
    } fetch_addr_fields_t;

    // Raw for PC arithmetic, fields for cache indexing
    typedef union packed {
        logic   [31:0]                  raw;
        fetch_addr_fields_t             f;
    } fetch_addr_t;

    typedef struct packed {
        logic                           valid;
        fetch_addr_t                    addr;
    } ic_req_t;

    typedef struct packed {
        logic                           valid;
        logic   [31:0]                  inst;
        logic   [31:0]                  pc;     // PC of the fetched word
    } ic_resp_t;

    typedef struct packed {
        logic   [31:0]                  pc;
        logic   [31:0]                  inst;
    } iq_entry_t;

endpackage : fetch_pkg

/* hdl/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// PC after reset
`define FETCH_RESET_VEC     32'h1eceb000

// Instruction queue entries
`define IQ_DEPTH            16

// Direct-mapped cache, one 32-byte line per set
`define IC_SETS             16
`define IC_SET_BITS         $clog2(`IC_SETS)
`define IC_WORD_BITS        3
`define IC_BYTE_BITS        2
`define IC_TAG_BITS         (32 - `IC_SET_BITS - `IC_WORD_BITS - `IC_BYTE_BITS)
`define IC_LINE_BITS        256

// Memory burst geometry
`define BEAT_BITS           64
`define BEATS_PER_LINE      4

`endif
